// File: vlog.f
+incdir+include
verilog/ex_pkg.sv
verilog/alu_ex.sv
verilog/hilo_unit.sv
verilog/div_iter.sv
verilog/ex_stage.sv
test/ex_stage_properties.sv
test/ex_stage_tb.sv

// File: Makefile
# Verilator build and run of the execute stage testbench
# the run exits nonzero when the testbench fails

sim:
	verilator --binary --timing --assert -f vlog.f --top-module ex_stage_tb -o ex_stage_tb
	./obj_dir/ex_stage_tb

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: test/ex_stage_tb.sv
/*
 * testbench for the execute stage
 * directed LL/SC, count, store, unaligned load, multiply and divide cases,
 * then random instructions under random output back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module ex_stage_tb;
    import ex_pkg::*;

    localparam int N_INSTR        = 300;
    localparam int TIMEOUT_CYCLES = N_INSTR * 40;

    // byte tables indexed by the low address bits
    localparam logic [3:0] SB_WEN [4]  = '{4'b0001, 4'b0010, 4'b0100, 4'b1000};
    localparam logic [3:0] SH_WEN [4]  = '{4'b0011, 4'b0000, 4'b1100, 4'b0000};
    localparam logic [3:0] SWL_WEN [4] = '{4'b0001, 4'b0011, 4'b0111, 4'b1111};
    localparam logic [3:0] SWR_WEN [4] = '{4'b1111, 4'b1110, 4'b1100, 4'b1000};
    localparam logic [3:0] LWL_SEL [4] = '{4'b1000, 4'b1100, 4'b1110, 4'b1111};
    localparam logic [3:0] LWR_SEL [4] = '{4'b1111, 4'b0111, 4'b0011, 4'b0001};

    localparam alu_op_e STORE_OPS [5] = '{ALU_SB, ALU_SH, ALU_SW, ALU_SWL, ALU_SWR};
    localparam alu_op_e MUL_SEQ [10]  = '{ALU_MULT, ALU_MFHI, ALU_MFLO, ALU_MADD, ALU_MSUB,
                                          ALU_MFLO, ALU_MULTU, ALU_MADDU, ALU_MSUBU, ALU_MUL};

    logic       clk;
    logic       reset;
    logic       in_valid;
    logic       in_ready;
    ex_req_t    in_req;
    logic       out_valid;
    logic       out_ready;
    ex_result_t out_res;

    integer              seed = 32'h9206;
    int                  n_checked = 0;
    int                  cycles = 0;
    ex_result_t          expect_q [$];
    // architectural state seen by the reference
    logic [`EX_WORD-1:0] ref_hi = '0;
    logic [`EX_WORD-1:0] ref_lo = '0;
    logic                ref_ll = 1'b0;

    ex_stage u_ex_stage (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_req(in_req),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_res(out_res)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic ex_req_t make_req(input int idx);
        ex_req_t     r;
        logic [31:0] rnd;
        int          k;
        r.pc     = $random(seed);
        r.opr1   = $random(seed);
        r.opr2   = $random(seed);
        r.offset = $random(seed);
        rnd      = $random(seed);
        r.wreg   = rnd[8];
        rnd      = $random(seed);
        r.op     = alu_op_e'(6'(rnd % 45));
        if (idx < 3) begin
            // SC with no reservation, then LL, then SC again
            r.op = (idx == 1) ? ALU_LL : ALU_SC;
        end else if (idx < 7) begin
            k      = idx - 3;
            r.op   = k[0] ? ALU_CLO : ALU_CLZ;
            r.opr1 = k[1] ? 32'hffff_ffff : 32'h0;
        end else if (idx < 27) begin
            k        = idx - 7;
            r.op     = STORE_OPS[3'(k / 4)];
            r.opr1   = {r.opr1[31:2], 2'b00};
            r.offset = {r.offset[31:2], k[1:0]};
        end else if (idx < 35) begin
            k        = idx - 27;
            r.op     = k[2] ? ALU_LWR : ALU_LWL;
            r.opr1   = {r.opr1[31:2], 2'b00};
            r.offset = {r.offset[31:2], k[1:0]};
        end else if (idx < 45) begin
            // walk through all operand sign combinations
            k          = idx - 35;
            r.op       = MUL_SEQ[4'(k)];
            r.opr1[31] = k[0];
            r.opr2[31] = k[1];
        end else if (idx < 49) begin
            k          = idx - 45;
            r.op       = k[0] ? ALU_DIVU : ALU_DIV;
            r.opr1[31] = 1'b1;
            if (!k[1])
                r.opr2 = '0;
        end
        return r;
    endfunction

    function automatic ex_result_t ref_exec(input ex_req_t r);
        ex_result_t  e;
        logic [31:0] addr;
        logic [1:0]  b;
        logic [63:0] sprod;
        logic [63:0] uprod;
        logic        lead;
        logic        sgn;
        logic [31:0] ma;
        logic [31:0] mb;
        logic [31:0] q;
        logic [31:0] rm;
        int          n;
        e         = '0;
        addr      = r.opr1 + r.offset;
        b         = addr[1:0];
        sprod     = 64'($signed(r.opr1)) * 64'($signed(r.opr2));
        uprod     = {32'b0, r.opr1} * {32'b0, r.opr2};
        e.wregsel = {4{r.wreg}};
        if (r.op inside {ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW, ALU_LWL, ALU_LWR, ALU_LL,
                         ALU_SB, ALU_SH, ALU_SW, ALU_SWL, ALU_SWR}) begin
            e.mem.en    = 1'b1;
            e.mem.vaddr = addr;
        end
        if (r.op inside {ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW, ALU_LWL, ALU_LWR, ALU_LL,
                         ALU_MUL, ALU_MFHI, ALU_MFLO})
            e.res_pending = 1'b1;
        case (r.op)
            ALU_SLL:            e.alures = r.opr2 << r.opr1[4:0];
            ALU_SRL:            e.alures = r.opr2 >> r.opr1[4:0];
            ALU_SRA:            e.alures = $signed(r.opr2) >>> r.opr1[4:0];
            ALU_ADD, ALU_ADDU:  e.alures = r.opr1 + r.opr2;
            ALU_SUB, ALU_SUBU:  e.alures = r.opr1 - r.opr2;
            ALU_SLT:            e.alures = {31'b0, $signed(r.opr1) < $signed(r.opr2)};
            ALU_SLTU:           e.alures = {31'b0, r.opr1 < r.opr2};
            ALU_AND:            e.alures = r.opr1 & r.opr2;
            ALU_OR:             e.alures = r.opr1 | r.opr2;
            ALU_XOR:            e.alures = r.opr1 ^ r.opr2;
            ALU_NOR:            e.alures = ~(r.opr1 | r.opr2);
            ALU_MOV:            e.alures = r.opr1;
            ALU_MTHI: begin
                e.alures = r.opr1;
                ref_hi   = r.opr1;
            end
            ALU_MTLO: begin
                e.alures = r.opr1;
                ref_lo   = r.opr1;
            end
            ALU_MFHI:           e.alures = ref_hi;
            ALU_MFLO:           e.alures = ref_lo;
            ALU_CLO, ALU_CLZ: begin
                lead = (r.op == ALU_CLO);
                n    = 0;
                while (n < 32 && r.opr1[31 - n] == lead)
                    n++;
                e.alures = n;
            end
            ALU_BAL:            e.alures = r.pc + 32'd8;
            ALU_MUL:            e.alures = sprod[31:0];
            ALU_MULT:           {ref_hi, ref_lo} = sprod;
            ALU_MULTU:          {ref_hi, ref_lo} = uprod;
            ALU_MADD:           {ref_hi, ref_lo} = {ref_hi, ref_lo} + sprod;
            ALU_MADDU:          {ref_hi, ref_lo} = {ref_hi, ref_lo} + uprod;
            ALU_MSUB:           {ref_hi, ref_lo} = {ref_hi, ref_lo} - sprod;
            ALU_MSUBU:          {ref_hi, ref_lo} = {ref_hi, ref_lo} - uprod;
            ALU_DIV, ALU_DIVU: begin
                // magnitudes first, zero divisor gives all ones
                sgn = (r.op == ALU_DIV);
                ma  = (sgn && r.opr1[31]) ? -r.opr1 : r.opr1;
                mb  = (sgn && r.opr2[31]) ? -r.opr2 : r.opr2;
                if (mb == 32'h0) begin
                    q  = 32'hffff_ffff;
                    rm = ma;
                end else begin
                    q  = ma / mb;
                    rm = ma % mb;
                end
                ref_lo = (sgn && (r.opr1[31] ^ r.opr2[31])) ? -q : q;
                ref_hi = (sgn && r.opr1[31]) ? -rm : rm;
            end
            ALU_LWL:            e.wregsel = LWL_SEL[b];
            ALU_LWR:            e.wregsel = LWR_SEL[b];
            ALU_LL:             ref_ll = 1'b1;
            ALU_SB: begin
                e.mem.wdata = {4{r.opr2[7:0]}};
                e.mem.wen   = SB_WEN[b];
            end
            ALU_SH: begin
                e.mem.wdata = {2{r.opr2[15:0]}};
                e.mem.wen   = SH_WEN[b];
            end
            ALU_SW: begin
                e.mem.wdata = r.opr2;
                e.mem.wen   = 4'b1111;
            end
            ALU_SWL: begin
                e.mem.vaddr = {addr[31:2], 2'b00};
                e.mem.wdata = r.opr2 >> (5'd24 - {b, 3'b000});
                e.mem.wen   = SWL_WEN[b];
            end
            ALU_SWR: begin
                e.mem.vaddr = {addr[31:2], 2'b00};
                e.mem.wdata = r.opr2 << {b, 3'b000};
                e.mem.wen   = SWR_WEN[b];
            end
            ALU_SC: begin
                e.alures = {31'b0, ref_ll};
                if (ref_ll) begin
                    e.mem.en    = 1'b1;
                    e.mem.vaddr = addr;
                    e.mem.wdata = r.opr2;
                    e.mem.wen   = 4'b1111;
                end
            end
            default:            e.alures = '0;
        endcase
        e.hi = ref_hi;
        e.lo = ref_lo;
        return e;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("Fail %s in result %0d: got %h expected %h", name, n_checked, got, want);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [`EX_WORD-1:0] got,
                              input logic [`EX_WORD-1:0] want);
        if (got !== want)
            report_mismatch(name, got, want);
    endtask

    task automatic check_mem(input mem_req_t got, input mem_req_t want);
        if (got.en !== want.en)
            report_mismatch("mem.en", {31'b0, got.en}, {31'b0, want.en});
        if (got.wen !== want.wen)
            report_mismatch("mem.wen", {28'b0, got.wen}, {28'b0, want.wen});
        check_word("mem.vaddr", got.vaddr, want.vaddr);
        check_word("mem.wdata", got.wdata, want.wdata);
    endtask

    task automatic check_result(input ex_result_t got, input ex_result_t want);
        check_word("alures", got.alures, want.alures);
        if (got.res_pending !== want.res_pending)
            report_mismatch("res_pending", {31'b0, got.res_pending}, {31'b0, want.res_pending});
        if (got.wregsel !== want.wregsel)
            report_mismatch("wregsel", {28'b0, got.wregsel}, {28'b0, want.wregsel});
        check_mem(got.mem, want.mem);
        check_word("hi", got.hi, want.hi);
        check_word("lo", got.lo, want.lo);
    endtask

    initial begin : drive
        int          i;
        logic [31:0] rnd;
        logic        accepted;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_req    = '0;
        out_ready = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        for (i = 0; i < N_INSTR; i++) begin
            in_req   = make_req(i);
            in_valid = 1'b1;
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                if (in_ready) begin
                    expect_q.push_back(ref_exec(in_req));
                    accepted = 1'b1;
                end
                @(posedge clk);
                #1;
                rnd       = $random(seed);
                out_ready = (rnd[1:0] != 2'b00);
            end
        end
        in_valid  = 1'b0;
        out_ready = 1'b1;
        wait (n_checked == N_INSTR);
        // a few idle cycles catch any stray output
        repeat (3) @(negedge clk);
        $display("Simulation finished: PASS");
        $finish;
    end

    initial begin : compare
        ex_result_t want;
        forever begin
            @(negedge clk);
            if (!reset && out_valid && out_ready) begin
                if (expect_q.size() == 0) begin
                    $display("output transfer with no instruction outstanding");
                    $display("Simulation finished: FAIL");
                    $fatal(1);
                end else begin
                    want = expect_q.pop_front();
                    check_result(out_res, want);
                    n_checked++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d results checked", cycles, n_checked);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// File: test/ex_stage_properties.sv
/*
 * handshake assertions for the execute stage
 * bound into every ex_stage instance
 */
`timescale 1ns/1ps
`default_nettype none

module ex_stage_properties (
    input wire                     clk,
    input wire                     reset,
    input wire                     in_ready,
    input wire                     out_valid,
    input wire                     out_ready,
    input wire ex_pkg::ex_result_t out_res,
    input wire                     div_busy
);

    // stalled result keeps valid and payload
    a_hold: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_res)))
        else $error("out_res or out_valid changed under back-pressure");

    // a running divide blocks new input and has no result on the output yet
    a_div_busy: assert property (@(posedge clk) disable iff (reset)
        div_busy |-> (!in_ready && !out_valid))
        else $error("in_ready or out_valid high while the divider is busy");

    a_reset: assert property (@(posedge clk)
        reset |=> (!out_valid && in_ready))
        else $error("out_valid high or in_ready low after reset");

endmodule

bind ex_stage ex_stage_properties u_props (
    .clk(clk),
    .reset(reset),
    .in_ready(in_ready),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_res(out_res),
    .div_busy(div_busy)
);

`default_nettype wire

// File: verilog/ex_stage.sv
/*
 * execute stage top with valid/ready on both sides
 * one instruction in flight, 1 cycle latency, divides wait on div_iter
 */
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module ex_stage (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      in_valid,
    output logic                     in_ready,
    input  wire ex_pkg::ex_req_t     in_req,
    output logic                     out_valid,
    input  wire                      out_ready,
    output ex_pkg::ex_result_t       out_res
);
    import ex_pkg::*;

    ex_req_t             req_q;
    logic                req_valid;
    logic                llbit;
    logic [`EX_WORD-1:0] alures;
    logic                res_pending;
    logic [3:0]          wregsel;
    mem_req_t            alu_mem;
    mul_parts_t          parts;
    logic                div_start;
    logic                div_signed;
    logic                llb_wen;
    logic                llbit_next;
    logic [`EX_WORD-1:0] hi;
    logic [`EX_WORD-1:0] lo;
    logic [`EX_WORD-1:0] mul_word;
    logic                div_busy;
    logic                div_done;
    logic [`EX_WORD-1:0] quot;
    logic [`EX_WORD-1:0] rem;
    logic [`EX_WORD-1:0] alures_q;
    logic                pending_q;
    logic [3:0]          wregsel_q;
    mem_req_t            mem_q;

    // idle only with nothing held, no divide running and output free
    assign in_ready = !req_valid && !div_busy && !div_done && (!out_valid || out_ready);

    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid <= 1'b0;
            llbit     <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            req_valid <= in_valid && in_ready;
            if (req_valid && llb_wen)
                llbit <= llbit_next;
            if ((req_valid && !div_start) || div_done)
                out_valid <= 1'b1;
            else if (out_ready)
                out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready)
            req_q <= in_req;
        // divides capture here too, then wait for div_done
        if (req_valid) begin
            alures_q  <= (req_q.op inside {ALU_MUL, ALU_MFHI, ALU_MFLO}) ? mul_word : alures;
            pending_q <= res_pending;
            wregsel_q <= wregsel;
            mem_q     <= alu_mem;
        end
    end

    always_comb begin
        out_res.alures      = alures_q;
        out_res.res_pending = pending_q;
        out_res.wregsel     = wregsel_q;
        out_res.mem         = mem_q;
        out_res.hi          = hi;
        out_res.lo          = lo;
    end

    alu_ex u_alu (
        .req(req_q), .llbit_in(llbit), .alures(alures), .res_pending(res_pending),
        .wregsel(wregsel), .mem(alu_mem), .parts(parts), .div_start(div_start),
        .div_signed(div_signed), .llb_wen(llb_wen), .llbit_next(llbit_next)
    );

    hilo_unit u_hilo (
        .clk(clk), .reset(reset), .commit(req_valid), .op(req_q.op), .parts(parts),
        .opr1(req_q.opr1), .div_done(div_done), .quot(quot), .rem(rem),
        .hi(hi), .lo(lo), .mul_word(mul_word)
    );

    div_iter u_div (
        .clk(clk), .reset(reset), .start(req_valid && div_start), .signed_op(div_signed),
        .dividend(req_q.opr1), .divisor(req_q.opr2), .busy(div_busy), .done(div_done),
        .quot(quot), .rem(rem)
    );

endmodule

`default_nettype wire

// File: verilog/div_iter.sv
/*
 * iterative restoring divider, one quotient bit per cycle
 * pulse start with the operands, done follows after the last step
 * and quot/rem are valid while done is high
 */
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module div_iter (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 start,
    input  wire                 signed_op,
    input  wire [`EX_WORD-1:0]  dividend,
    input  wire [`EX_WORD-1:0]  divisor,
    output logic                busy,
    output logic                done,
    output logic [`EX_WORD-1:0] quot,
    output logic [`EX_WORD-1:0] rem
);
    localparam int CNT_W = $clog2(`EX_DIV_STEPS);

    logic [CNT_W-1:0]    step_cnt;
    // dividend bits shift out the top, quotient bits shift in below
    logic [`EX_WORD-1:0] shift_q;
    logic [`EX_WORD-1:0] dvsr_q;
    logic [`EX_WORD-1:0] rem_q;
    logic                neg_quot;
    logic                neg_rem;
    logic [`EX_WORD-1:0] dividend_mag;
    logic [`EX_WORD-1:0] divisor_mag;
    logic [`EX_WORD:0]   partial;
    logic [`EX_WORD:0]   diff;

    assign dividend_mag = (signed_op && dividend[`EX_WORD-1]) ? -dividend : dividend;
    assign divisor_mag  = (signed_op && divisor[`EX_WORD-1]) ? -divisor : divisor;

    assign partial = {rem_q, shift_q[`EX_WORD-1]};
    assign diff    = partial - {1'b0, dvsr_q};

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            step_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy     <= 1'b1;
                step_cnt <= '0;
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (step_cnt == CNT_W'(`EX_DIV_STEPS - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // zero divisor never borrows, so quotient ends all ones
    always_ff @(posedge clk) begin
        if (start) begin
            shift_q  <= dividend_mag;
            dvsr_q   <= divisor_mag;
            rem_q    <= '0;
            neg_quot <= signed_op && (dividend[`EX_WORD-1] ^ divisor[`EX_WORD-1]);
            neg_rem  <= signed_op && dividend[`EX_WORD-1];
        end else if (busy) begin
            if (diff[`EX_WORD]) begin
                rem_q   <= partial[`EX_WORD-1:0];
                shift_q <= {shift_q[`EX_WORD-2:0], 1'b0};
            end else begin
                rem_q   <= diff[`EX_WORD-1:0];
                shift_q <= {shift_q[`EX_WORD-2:0], 1'b1};
            end
        end
    end

    assign quot = neg_quot ? -shift_q : shift_q;
    assign rem  = neg_rem ? -rem_q : rem_q;

endmodule

`default_nettype wire

// File: verilog/hilo_unit.sv
/*
 * HI/LO register pair with the multiply back end
 * sums partial products, runs MADD/MSUB accumulation, takes divider
 * results and MTHI/MTLO writes, and returns the word for MUL/MFHI/MFLO
 */
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module hilo_unit (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      commit,
    input  wire ex_pkg::alu_op_e     op,
    input  wire ex_pkg::mul_parts_t  parts,
    input  wire [`EX_WORD-1:0]       opr1,
    input  wire                      div_done,
    input  wire [`EX_WORD-1:0]       quot,
    input  wire [`EX_WORD-1:0]       rem,
    output logic [`EX_WORD-1:0]      hi,
    output logic [`EX_WORD-1:0]      lo,
    output logic [`EX_WORD-1:0]      mul_word
);
    import ex_pkg::*;

    logic [`EX_DWORD-1:0] prod_mag;
    logic [`EX_DWORD-1:0] product;
    logic [`EX_DWORD-1:0] hilo_cur;

    // cross terms sit 16 bits up
    assign prod_mag = {32'b0, parts.pp_ll}
                    + {16'b0, parts.pp_hl, 16'b0}
                    + {16'b0, parts.pp_lh, 16'b0}
                    + {parts.pp_hh, 32'b0};

    assign product  = parts.mul_neg ? -prod_mag : prod_mag;
    assign hilo_cur = {hi, lo};

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (div_done) begin
            hi <= rem;
            lo <= quot;
        end else if (commit) begin
            case (op)
                ALU_MULT, ALU_MULTU: {hi, lo} <= product;
                ALU_MADD, ALU_MADDU: {hi, lo} <= hilo_cur + product;
                ALU_MSUB, ALU_MSUBU: {hi, lo} <= hilo_cur - product;
                ALU_MTHI:            hi <= opr1;
                ALU_MTLO:            lo <= opr1;
                default: begin
                    hi <= hi;
                    lo <= lo;
                end
            endcase
        end
    end

    // MUL leaves HI/LO alone and only returns the low word
    always_comb begin
        case (op)
            ALU_MUL:  mul_word = product[`EX_WORD-1:0];
            ALU_MFHI: mul_word = hi;
            ALU_MFLO: mul_word = lo;
            default:  mul_word = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/alu_ex.sv
/*
 * combinational core of the execute stage
 * ALU results, CLO/CLZ, multiply partial products, divide start
 * and memory request shaping for loads, stores and LL/SC
 */
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module alu_ex (
    input  wire ex_pkg::ex_req_t     req,
    input  wire                      llbit_in,
    output logic [`EX_WORD-1:0]      alures,
    output logic                     res_pending,
    output logic [3:0]               wregsel,
    output ex_pkg::mem_req_t         mem,
    output ex_pkg::mul_parts_t       parts,
    output logic                     div_start,
    output logic                     div_signed,
    output logic                     llb_wen,
    output logic                     llbit_next
);
    import ex_pkg::*;

    logic                opr1_s;
    logic                opr2_s;
    logic [`EX_WORD-1:0] abs_opr1;
    logic [`EX_WORD-1:0] abs_opr2;
    logic [`EX_WORD-1:0] clz_src;
    logic [15:0]         part16;
    logic [7:0]          part8;
    logic [3:0]          part4;
    logic [5:0]          clz_cnt;
    logic [`EX_WORD-1:0] mopr1;
    logic [`EX_WORD-1:0] mopr2;
    logic [`EX_WORD-1:0] sl_addr;
    logic [1:0]          boff;
    logic [3:0]          sel_l;
    logic [3:0]          sel_r;

    assign opr1_s   = req.opr1[`EX_WORD-1];
    assign opr2_s   = req.opr2[`EX_WORD-1];
    assign abs_opr1 = opr1_s ? -req.opr1 : req.opr1;
    assign abs_opr2 = opr2_s ? -req.opr2 : req.opr2;

    // binary leading zero search, CLO searches the inverted word
    always_comb begin
        clz_src = (req.op == ALU_CLO) ? ~req.opr1 : req.opr1;
        part16  = (clz_src[31:16] == 16'b0) ? clz_src[15:0] : clz_src[31:16];
        part8   = (part16[15:8] == 8'b0) ? part16[7:0] : part16[15:8];
        part4   = (part8[7:4] == 4'b0) ? part8[3:0] : part8[7:4];
        if (clz_src == '0) begin
            clz_cnt = 6'd32;
        end else begin
            clz_cnt[5] = 1'b0;
            clz_cnt[4] = (clz_src[31:16] == 16'b0);
            clz_cnt[3] = (part16[15:8] == 8'b0);
            clz_cnt[2] = (part8[7:4] == 4'b0);
            casez (part4)
                4'b1???: clz_cnt[1:0] = 2'd0;
                4'b01??: clz_cnt[1:0] = 2'd1;
                4'b001?: clz_cnt[1:0] = 2'd2;
                default: clz_cnt[1:0] = 2'd3;
            endcase
        end
    end

    // signed multiplies work on magnitudes, sign restored in hilo_unit
    always_comb begin
        case (req.op)
            ALU_MUL, ALU_MULT, ALU_MADD, ALU_MSUB: begin
                mopr1         = abs_opr1;
                mopr2         = abs_opr2;
                parts.mul_neg = opr1_s ^ opr2_s;
            end
            ALU_MULTU, ALU_MADDU, ALU_MSUBU: begin
                mopr1         = req.opr1;
                mopr2         = req.opr2;
                parts.mul_neg = 1'b0;
            end
            default: begin
                mopr1         = '0;
                mopr2         = '0;
                parts.mul_neg = 1'b0;
            end
        endcase
        parts.pp_ll = mopr1[15:0] * mopr2[15:0];
        parts.pp_hl = mopr1[31:16] * mopr2[15:0];
        parts.pp_lh = mopr1[15:0] * mopr2[31:16];
        parts.pp_hh = mopr1[31:16] * mopr2[31:16];
    end

    assign div_start  = (req.op == ALU_DIV) || (req.op == ALU_DIVU);
    assign div_signed = (req.op == ALU_DIV);

    assign sl_addr = req.opr1 + req.offset;
    assign boff    = sl_addr[1:0];

    // register byte masks for unaligned loads
    assign sel_l = 4'b1111 << ~boff;
    assign sel_r = 4'b1111 >> boff;

    always_comb begin
        mem        = '0;
        wregsel    = {4{req.wreg}};
        llb_wen    = 1'b0;
        llbit_next = llbit_in;
        case (req.op)
            ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW: begin
                mem.en    = 1'b1;
                mem.vaddr = sl_addr;
            end
            ALU_LWL, ALU_LWR: begin
                mem.en    = 1'b1;
                mem.vaddr = sl_addr;
                wregsel   = (req.op == ALU_LWL) ? sel_l : sel_r;
            end
            ALU_LL: begin
                mem.en     = 1'b1;
                mem.vaddr  = sl_addr;
                llb_wen    = 1'b1;
                llbit_next = 1'b1;
            end
            ALU_SB: begin
                mem.en    = 1'b1;
                mem.vaddr = sl_addr;
                mem.wdata = {4{req.opr2[7:0]}};
                mem.wen   = 4'b0001 << boff;
            end
            ALU_SH: begin
                mem.en    = 1'b1;
                mem.vaddr = sl_addr;
                mem.wdata = {2{req.opr2[15:0]}};
                // misaligned halfword writes nothing
                case (boff)
                    2'b00:   mem.wen = 4'b0011;
                    2'b10:   mem.wen = 4'b1100;
                    default: mem.wen = 4'b0000;
                endcase
            end
            ALU_SW: begin
                mem.en    = 1'b1;
                mem.vaddr = sl_addr;
                mem.wdata = req.opr2;
                mem.wen   = 4'b1111;
            end
            ALU_SWL: begin
                mem.en    = 1'b1;
                mem.vaddr = {sl_addr[`EX_WORD-1:2], 2'b00};
                mem.wdata = req.opr2 >> {~boff, 3'b000};
                mem.wen   = 4'b1111 >> ~boff;
            end
            ALU_SWR: begin
                mem.en    = 1'b1;
                mem.vaddr = {sl_addr[`EX_WORD-1:2], 2'b00};
                mem.wdata = req.opr2 << {boff, 3'b000};
                mem.wen   = 4'b1111 << boff;
            end
            ALU_SC: begin
                if (llbit_in) begin
                    mem.en    = 1'b1;
                    mem.vaddr = sl_addr;
                    mem.wdata = req.opr2;
                    mem.wen   = 4'b1111;
                end
            end
            default: begin
                mem = '0;
            end
        endcase
    end

    always_comb begin
        case (req.op)
            ALU_SLL:            alures = req.opr2 << req.opr1[4:0];
            ALU_SRL:            alures = req.opr2 >> req.opr1[4:0];
            ALU_SRA:            alures = $signed(req.opr2) >>> req.opr1[4:0];
            ALU_ADD, ALU_ADDU:  alures = req.opr1 + req.opr2;
            ALU_SUB, ALU_SUBU:  alures = req.opr1 - req.opr2;
            ALU_AND:            alures = req.opr1 & req.opr2;
            ALU_OR:             alures = req.opr1 | req.opr2;
            ALU_XOR:            alures = req.opr1 ^ req.opr2;
            ALU_NOR:            alures = ~(req.opr1 | req.opr2);
            ALU_SLT:            alures = {31'b0, $signed(req.opr1) < $signed(req.opr2)};
            ALU_SLTU:           alures = {31'b0, req.opr1 < req.opr2};
            ALU_MOV, ALU_MTHI,
            ALU_MTLO:           alures = req.opr1;
            ALU_CLO, ALU_CLZ:   alures = {26'b0, clz_cnt};
            // return address skips the delay slot
            ALU_BAL:            alures = req.pc + 32'd8;
            ALU_SC:             alures = {31'b0, llbit_in};
            default:            alures = '0;
        endcase
    end

    // value comes from memory or HI/LO later, not from this ALU
    assign res_pending = req.op inside {ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW,
                                        ALU_LWL, ALU_LWR, ALU_LL,
                                        ALU_MUL, ALU_MFHI, ALU_MFLO};

endmodule

`default_nettype wire

// File: verilog/ex_pkg.sv
/*
 * types shared by the execute stage
 * operation codes plus request, memory request and result structs
 */
`default_nettype none

`include "ex_defines.svh"

package ex_pkg;

    typedef enum logic [5:0] {
        ALU_NOP,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_MOV, ALU_MTHI, ALU_MTLO, ALU_MFHI, ALU_MFLO,
        ALU_CLO, ALU_CLZ,
        ALU_BAL,
        ALU_MUL, ALU_MULT, ALU_MULTU, ALU_MADD, ALU_MADDU, ALU_MSUB, ALU_MSUBU,
        ALU_DIV, ALU_DIVU,
        ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW, ALU_LWL, ALU_LWR, ALU_LL,
        ALU_SB, ALU_SH, ALU_SW, ALU_SWL, ALU_SWR, ALU_SC
    } alu_op_e;

    typedef struct packed {
        logic [`EX_WORD-1:0] pc;
        alu_op_e             op;
        logic [`EX_WORD-1:0] opr1;
        logic [`EX_WORD-1:0] opr2;
        logic [`EX_WORD-1:0] offset;
        logic                wreg;
    } ex_req_t;

    typedef struct packed {
        logic                en;
        logic [3:0]          wen;
        logic [`EX_WORD-1:0] vaddr;
        logic [`EX_WORD-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [`EX_WORD-1:0] alures;
        logic                res_pending;
        logic [3:0]          wregsel;
        mem_req_t            mem;
        logic [`EX_WORD-1:0] hi;
        logic [`EX_WORD-1:0] lo;
    } ex_result_t;

    // 16x16 products of the operand magnitudes, first letter is opr1's half
    typedef struct packed {
        logic [`EX_WORD-1:0] pp_ll;
        logic [`EX_WORD-1:0] pp_hl;
        logic [`EX_WORD-1:0] pp_lh;
        logic [`EX_WORD-1:0] pp_hh;
        logic                mul_neg;
    } mul_parts_t;

endpackage

`default_nettype wire

// File: include/ex_defines.svh
/*
 * sizing macros for the execute stage
 * include wherever a word, a HI:LO pair or the divider length is needed
 */
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// data and address width
`define EX_WORD 32

// HI:LO pair, full multiply product
`define EX_DWORD 64

// restoring divider iterations, one quotient bit each
`define EX_DIV_STEPS 32

`endif
